//--- common/ternary_pkg.sv
// Trit and opcode types, trit codes, opcode values, operation select enum and trit helpers
package ternary_pkg;

    // One balanced trit in two bits
    typedef logic [1:0] trit_t;

    localparam trit_t TRIT_NEG  = 2'b11;
    localparam trit_t TRIT_ZERO = 2'b00;
    localparam trit_t TRIT_POS  = 2'b01;

    localparam int OPCODE_TRITS = 3;

    typedef logic [2*OPCODE_TRITS-1:0] opcode_t;

    // Opcodes as balanced values, trit 2 down to trit 0
    localparam opcode_t OP_NOT  = 6'b00_00_01;  // 0 0 +
    localparam opcode_t OP_AND  = 6'b00_01_11;  // 0 + -
    localparam opcode_t OP_ANDI = 6'b00_01_00;  // 0 + 0
    localparam opcode_t OP_OR   = 6'b00_01_01;  // 0 + +
    localparam opcode_t OP_XOR  = 6'b01_11_11;  // + - -
    localparam opcode_t OP_ADD  = 6'b01_11_00;  // + - 0
    localparam opcode_t OP_ADDI = 6'b01_11_01;  // + - +
    localparam opcode_t OP_SUB  = 6'b01_00_11;  // + 0 -
    localparam opcode_t OP_LT   = 6'b01_00_00;  // + 0 0
    localparam opcode_t OP_EQ   = 6'b01_00_01;  // + 0 +

    typedef enum logic [2:0] {
        SEL_NOT,
        SEL_AND,
        SEL_OR,
        SEL_XOR,
        SEL_ARITH,
        SEL_LT,
        SEL_EQ,
        SEL_PASS
    } alu_op_e;

    // The unused code 2'b10 reads as zero in every helper
    function automatic int trit_value(input trit_t t);
        case (t)
            TRIT_NEG: return -1;
            TRIT_POS: return 1;
            default:  return 0;
        endcase
    endfunction

    function automatic trit_t trit_neg(input trit_t t);
        case (t)
            TRIT_NEG: return TRIT_POS;
            TRIT_POS: return TRIT_NEG;
            default:  return TRIT_ZERO;
        endcase
    endfunction

    function automatic trit_t trit_min(input trit_t a, input trit_t b);
        if (a == TRIT_NEG || b == TRIT_NEG)
            return TRIT_NEG;
        if (a == TRIT_POS && b == TRIT_POS)
            return TRIT_POS;
        return TRIT_ZERO;
    endfunction

    function automatic trit_t trit_max(input trit_t a, input trit_t b);
        if (a == TRIT_POS || b == TRIT_POS)
            return TRIT_POS;
        if (a == TRIT_NEG && b == TRIT_NEG)
            return TRIT_NEG;
        return TRIT_ZERO;
    endfunction

    function automatic trit_t trit_xor(input trit_t a, input trit_t b);
        logic a_nz;
        logic b_nz;
        a_nz = (a == TRIT_POS) || (a == TRIT_NEG);
        b_nz = (b == TRIT_POS) || (b == TRIT_NEG);
        // Equal nonzero pairs give -1, opposite pairs cancel
        if (a_nz && b_nz)
            return (a == b) ? TRIT_NEG : TRIT_ZERO;
        if (a_nz)
            return a;
        if (b_nz)
            return b;
        return TRIT_ZERO;
    endfunction

endpackage

//--- verilog/alu_op_decoder.sv
// Opcode decoder producing the operation select and the subtract control
`timescale 1ns/100ps

module alu_op_decoder (
    input  ternary_pkg::opcode_t opcode,
    output ternary_pkg::alu_op_e op_sel,
    output logic                 subtract
);

    import ternary_pkg::*;

    always_comb begin
        op_sel   = SEL_PASS;
        subtract = 1'b0;
        case (opcode)
            OP_NOT: begin
                op_sel = SEL_NOT;
            end
            // ANDI is only an alias, no immediate path exists
            OP_AND, OP_ANDI: begin
                op_sel = SEL_AND;
            end
            OP_OR: begin
                op_sel = SEL_OR;
            end
            OP_XOR: begin
                op_sel = SEL_XOR;
            end
            OP_ADD, OP_ADDI: begin
                op_sel = SEL_ARITH;
            end
            OP_SUB: begin
                op_sel   = SEL_ARITH;
                subtract = 1'b1;
            end
            OP_LT: begin
                op_sel = SEL_LT;
            end
            OP_EQ: begin
                op_sel = SEL_EQ;
            end
            // Unknown codes, the old COMP included, pass input1 through
            default: begin
                op_sel = SEL_PASS;
            end
        endcase
    end

endmodule

//--- verilog/trit_logic_unit.sv
// Word-wide trit logic unit computing NOT, AND, OR and XOR
`timescale 1ns/100ps

module trit_logic_unit #(
    parameter int WORD_TRITS = 9
) (
    input  logic [2*WORD_TRITS-1:0] a,
    input  logic [2*WORD_TRITS-1:0] b,
    output logic [2*WORD_TRITS-1:0] not_result,
    output logic [2*WORD_TRITS-1:0] and_result,
    output logic [2*WORD_TRITS-1:0] or_result,
    output logic [2*WORD_TRITS-1:0] xor_result
);

    import ternary_pkg::*;

    for (genvar i = 0; i < WORD_TRITS; i++) begin : g_trit
        trit_t a_trit;
        trit_t b_trit;

        assign a_trit = a[2*i +: 2];
        assign b_trit = b[2*i +: 2];

        // NOT only looks at the first operand
        assign not_result[2*i +: 2] = trit_neg(a_trit);

        // AND and OR are min and max over -1 < 0 < +1
        assign and_result[2*i +: 2] = trit_min(a_trit, b_trit);
        assign or_result[2*i +: 2]  = trit_max(a_trit, b_trit);

        assign xor_result[2*i +: 2] = trit_xor(a_trit, b_trit);

        // Invalid operand codes must never leak to any result
        always_comb begin
            assert (not_result[2*i +: 2] !== 2'b10 &&
                    and_result[2*i +: 2] !== 2'b10 &&
                    or_result[2*i +: 2]  !== 2'b10 &&
                    xor_result[2*i +: 2] !== 2'b10)
                else $error("trit_logic_unit: invalid code in result trit %0d", i);
        end
    end

endmodule

//--- arith/ternary_ripple_adder.sv
// Balanced-ternary ripple adder with optional negation of the second operand
`timescale 1ns/100ps

module ternary_ripple_adder #(
    parameter int WORD_TRITS = 9
) (
    input  logic [2*WORD_TRITS-1:0] a,
    input  logic [2*WORD_TRITS-1:0] b,
    input  logic                    subtract,
    output logic [2*WORD_TRITS-1:0] sum
);

    import ternary_pkg::*;

    always_comb begin
        trit_t b_eff;
        trit_t carry;
        trit_t sum_trit;
        int    total;

        carry = TRIT_ZERO;
        for (int i = 0; i < WORD_TRITS; i++) begin
            // Subtraction adds the trit-wise negation of b
            b_eff = subtract ? trit_neg(b[2*i +: 2]) : b[2*i +: 2];
            total = trit_value(a[2*i +: 2]) + trit_value(b_eff) + trit_value(carry);

            // Digit total -3..3 splits into carry*3 + sum
            case (total)
                -3: begin
                    {carry, sum_trit} = {TRIT_NEG, TRIT_ZERO};
                end
                -2: begin
                    {carry, sum_trit} = {TRIT_NEG, TRIT_POS};
                end
                -1: begin
                    {carry, sum_trit} = {TRIT_ZERO, TRIT_NEG};
                end
                1: begin
                    {carry, sum_trit} = {TRIT_ZERO, TRIT_POS};
                end
                2: begin
                    {carry, sum_trit} = {TRIT_POS, TRIT_NEG};
                end
                3: begin
                    {carry, sum_trit} = {TRIT_POS, TRIT_ZERO};
                end
                default: begin
                    {carry, sum_trit} = {TRIT_ZERO, TRIT_ZERO};
                end
            endcase

            sum[2*i +: 2] = sum_trit;

            // Stage outputs stay inside the three legal codes
            assert (sum_trit !== 2'b10 && carry !== 2'b10)
                else $error("ternary_ripple_adder: invalid code at stage %0d", i);
        end
        // Carry out of the top trit is dropped, the sum wraps mod 3^WORD_TRITS
    end

endmodule

//--- arith/ternary_comparator.sv
// Signed less-than and equality chain over balanced-ternary words
`timescale 1ns/100ps

module ternary_comparator #(
    parameter int WORD_TRITS = 9
) (
    input  logic [2*WORD_TRITS-1:0] a,
    input  logic [2*WORD_TRITS-1:0] b,
    output logic                    lt,
    output logic                    eq
);

    import ternary_pkg::*;

    always_comb begin
        logic lt_so_far;
        logic eq_so_far;
        int   va;
        int   vb;

        // Nothing decided yet at the top of the word
        lt_so_far = 1'b0;
        eq_so_far = 1'b1;

        // Most significant trit first; the first differing trit decides
        for (int i = WORD_TRITS - 1; i >= 0; i--) begin
            va = trit_value(a[2*i +: 2]);
            vb = trit_value(b[2*i +: 2]);
            lt_so_far = lt_so_far || (eq_so_far && (va < vb));
            eq_so_far = eq_so_far && (va == vb);
        end

        lt = lt_so_far;
        eq = eq_so_far;

        assert (!(lt_so_far && eq_so_far))
            else $error("ternary_comparator: lt and eq both set");
    end

endmodule

//--- verilog/alu_result_register.sv
// Result select by operation and the enabled output register
`timescale 1ns/100ps

module alu_result_register #(
    parameter int WORD_TRITS = 9
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alu_enable,
    input  ternary_pkg::alu_op_e    op_sel,
    input  logic [2*WORD_TRITS-1:0] pass_value,
    input  logic [2*WORD_TRITS-1:0] not_result,
    input  logic [2*WORD_TRITS-1:0] and_result,
    input  logic [2*WORD_TRITS-1:0] or_result,
    input  logic [2*WORD_TRITS-1:0] xor_result,
    input  logic [2*WORD_TRITS-1:0] arith_result,
    input  logic                    lt,
    input  logic                    eq,
    output logic [2*WORD_TRITS-1:0] alu_out
);

    import ternary_pkg::*;

    logic [2*WORD_TRITS-1:0] lt_word;
    logic [2*WORD_TRITS-1:0] eq_word;
    logic [2*WORD_TRITS-1:0] next_word;

    // Flags become +1 in trit 0 and zero elsewhere
    assign lt_word = {{(WORD_TRITS-1){TRIT_ZERO}}, (lt ? TRIT_POS : TRIT_ZERO)};
    assign eq_word = {{(WORD_TRITS-1){TRIT_ZERO}}, (eq ? TRIT_POS : TRIT_ZERO)};

    always_comb begin
        case (op_sel)
            SEL_NOT:   next_word = not_result;
            SEL_AND:   next_word = and_result;
            SEL_OR:    next_word = or_result;
            SEL_XOR:   next_word = xor_result;
            SEL_ARITH: next_word = arith_result;
            SEL_LT:    next_word = lt_word;
            SEL_EQ:    next_word = eq_word;
            default:   next_word = pass_value;
        endcase
    end

    // Reset wins over the enable and clears to all zero trits
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_out <= '0;
        end else if (alu_enable) begin
            alu_out <= next_word;
        end
    end

    // A cycle without enable or reset leaves the output untouched
    a_hold_when_idle: assert property (
        @(posedge clock) (!reset && !alu_enable) |=> $stable(alu_out)
    ) else $error("alu_result_register: alu_out changed while idle");

endmodule

//--- verilog/ternary_alu.sv
// Ternary ALU top level with decoder, logic unit, adder, comparator and result register
`timescale 1ns/100ps

module ternary_alu #(
    parameter int WORD_TRITS = 9
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alu_enable,
    input  ternary_pkg::opcode_t    opcode,
    input  logic [2*WORD_TRITS-1:0] input1,
    input  logic [2*WORD_TRITS-1:0] input2,
    output logic [2*WORD_TRITS-1:0] alu_out
);

    import ternary_pkg::*;

    alu_op_e                 op_sel;
    logic                    subtract;
    logic [2*WORD_TRITS-1:0] not_result;
    logic [2*WORD_TRITS-1:0] and_result;
    logic [2*WORD_TRITS-1:0] or_result;
    logic [2*WORD_TRITS-1:0] xor_result;
    logic [2*WORD_TRITS-1:0] arith_result;
    logic                    lt;
    logic                    eq;

    alu_op_decoder u_decoder (
        .opcode   (opcode),
        .op_sel   (op_sel),
        .subtract (subtract)
    );

    // Trit-wise logic, all four results in parallel
    trit_logic_unit #(
        .WORD_TRITS (WORD_TRITS)
    ) u_logic (
        .a          (input1),
        .b          (input2),
        .not_result (not_result),
        .and_result (and_result),
        .or_result  (or_result),
        .xor_result (xor_result)
    );

    // Shared by ADD, ADDI and SUB
    ternary_ripple_adder #(
        .WORD_TRITS (WORD_TRITS)
    ) u_adder (
        .a        (input1),
        .b        (input2),
        .subtract (subtract),
        .sum      (arith_result)
    );

    ternary_comparator #(
        .WORD_TRITS (WORD_TRITS)
    ) u_compare (
        .a  (input1),
        .b  (input2),
        .lt (lt),
        .eq (eq)
    );

    alu_result_register #(
        .WORD_TRITS (WORD_TRITS)
    ) u_result (
        .clock        (clock),
        .reset        (reset),
        .alu_enable   (alu_enable),
        .op_sel       (op_sel),
        .pass_value   (input1),
        .not_result   (not_result),
        .and_result   (and_result),
        .or_result    (or_result),
        .xor_result   (xor_result),
        .arith_result (arith_result),
        .lt           (lt),
        .eq           (eq),
        .alu_out      (alu_out)
    );

endmodule

//--- testbench/tb_ternary_ref.svh
// Reference model functions for trit word conversion and expected ALU results
`ifndef TB_TERNARY_REF_SVH
`define TB_TERNARY_REF_SVH

// Only 2'b11 and 2'b01 carry a nonzero value
function automatic int trit_to_int(input logic [1:0] t);
    if (t == 2'b11)
        return -1;
    if (t == 2'b01)
        return 1;
    return 0;
endfunction

function automatic logic [1:0] int_to_trit(input int v);
    if (v < 0)
        return 2'b11;
    if (v > 0)
        return 2'b01;
    return 2'b00;
endfunction

function automatic int word_to_int(input logic [WORD_BITS-1:0] w);
    int value;
    value = 0;
    for (int i = WORD_TRITS - 1; i >= 0; i--) begin
        value = value * 3 + trit_to_int(w[2*i +: 2]);
    end
    return value;
endfunction

// Balanced digits, remainder folded into -1..+1
function automatic logic [WORD_BITS-1:0] int_to_word(input int v);
    logic [WORD_BITS-1:0] w;
    int rest;
    int digit;
    rest = v;
    w = '0;
    for (int i = 0; i < WORD_TRITS; i++) begin
        digit = rest % 3;
        if (digit == 2)
            digit = -1;
        else if (digit == -2)
            digit = 1;
        rest = (rest - digit) / 3;
        w[2*i +: 2] = int_to_trit(digit);
    end
    return w;
endfunction

function automatic logic [2*OPCODE_TRITS-1:0] int_to_opcode(input int v);
    logic [WORD_BITS-1:0] w;
    w = int_to_word(v);
    return w[2*OPCODE_TRITS-1:0];
endfunction

// Wraps modulo 3^WORD_TRITS into the balanced range
function automatic int wrap_balanced(input int v);
    int r;
    r = (v + HALF_RANGE) % MODULUS;
    if (r < 0)
        r = r + MODULUS;
    return r - HALF_RANGE;
endfunction

function automatic logic [WORD_BITS-1:0] expected_result(
    input logic [2*OPCODE_TRITS-1:0] op,
    input logic [WORD_BITS-1:0]      a,
    input logic [WORD_BITS-1:0]      b
);
    logic [WORD_BITS-1:0] result;
    int op_value;
    int x;
    int y;
    int r;
    op_value = word_to_int(WORD_BITS'(op));
    result = '0;
    case (op_value)
        1, 2, 3, 4, 5: begin
            for (int i = 0; i < WORD_TRITS; i++) begin
                x = trit_to_int(a[2*i +: 2]);
                y = trit_to_int(b[2*i +: 2]);
                case (op_value)
                    1:       r = -x;
                    2, 3:    r = (x < y) ? x : y;
                    4:       r = (x > y) ? x : y;
                    default: r = (x != 0 && y != 0) ? ((x == y) ? -1 : 0) : x + y;
                endcase
                result[2*i +: 2] = int_to_trit(r);
            end
            return result;
        end
        6, 7:    return int_to_word(wrap_balanced(word_to_int(a) + word_to_int(b)));
        8:       return int_to_word(wrap_balanced(word_to_int(a) - word_to_int(b)));
        9:       return int_to_word((word_to_int(a) < word_to_int(b)) ? 1 : 0);
        10:      return int_to_word((word_to_int(a) == word_to_int(b)) ? 1 : 0);
        default: return a;
    endcase
endfunction

`endif

//--- testbench/tb_ternary_alu.sv
// Testbench for the ternary ALU with reference model, compare process and watchdog
`timescale 1ns/100ps

module tb_ternary_alu;

    import ternary_pkg::*;

    localparam int WORD_TRITS   = 9;
    localparam int WORD_BITS    = 2 * WORD_TRITS;
    localparam int MODULUS      = 3 ** WORD_TRITS;
    localparam int HALF_RANGE   = (MODULUS - 1) / 2;
    localparam int CLOCK_PERIOD = 10;
    localparam int NUM_RANDOM   = 200;
    // Upper bound on reset, directed and tail cycles
    localparam int NUM_DIRECTED = 40;
    localparam int TIMEOUT_NS   = (NUM_RANDOM + NUM_DIRECTED + 20) * CLOCK_PERIOD;
    localparam int SEED         = 32'h3a43_5c28;

    localparam int OPV_XOR  = 5;
    localparam int OPV_ADD  = 6;
    localparam int OPV_ADDI = 7;
    localparam int OPV_SUB  = 8;
    localparam int OPV_LT   = 9;
    localparam int OPV_EQ   = 10;
    localparam int OPV_COMP = 11;

    `include "tb_ternary_ref.svh"

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 alu_enable;
    opcode_t              opcode;
    logic [WORD_BITS-1:0] input1;
    logic [WORD_BITS-1:0] input2;
    logic [WORD_BITS-1:0] alu_out;

    logic [WORD_BITS-1:0] expected_word;
    logic                 model_started = 1'b0;
    int                   error_count = 0;
    int                   check_count = 0;

    ternary_alu #(
        .WORD_TRITS (WORD_TRITS)
    ) DUT (
        .clock      (clock),
        .reset      (reset),
        .alu_enable (alu_enable),
        .opcode     (opcode),
        .input1     (input1),
        .input2     (input2),
        .alu_out    (alu_out)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] actual,
                              input logic [WORD_BITS-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic int random_operand();
        return int'($urandom_range(2 * HALF_RANGE)) - HALF_RANGE;
    endfunction

    // Mostly valid opcodes, the rest spread over all 27 three-trit values
    function automatic int random_opcode();
        if ($urandom_range(3) != 0)
            return int'($urandom_range(10, 1));
        return int'($urandom_range(26)) - 13;
    endfunction

    task automatic issue(input int op_value, input int a, input int b, input logic en);
        @(posedge clock);
        opcode     <= int_to_opcode(op_value);
        input1     <= int_to_word(a);
        input2     <= int_to_word(b);
        alu_enable <= en;
    endtask

    // Model register sees the same inputs as the DUT on each edge
    always @(posedge clock) begin
        if (reset) begin
            expected_word <= '0;
        end else if (alu_enable) begin
            expected_word <= expected_result(opcode, input1, input2);
        end
        model_started <= 1'b1;
    end

    always @(negedge clock) begin
        if (model_started) begin
            check_word("alu_out", alu_out, expected_word);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [WORD_BITS-1:0] held;

        void'($urandom(SEED));
        reset      = 1'b1;
        alu_enable = 1'b0;
        opcode     = '0;
        input1     = '0;
        input2     = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // No enable yet, so the cleared output must stay
        @(negedge clock);
        check_word("alu_out after reset", alu_out, '0);
        @(negedge clock);
        check_word("alu_out after reset", alu_out, '0);

        // XOR of equal and opposite nonzero trits
        issue(OPV_XOR, HALF_RANGE, HALF_RANGE, 1'b1);
        issue(OPV_XOR, -HALF_RANGE, -HALF_RANGE, 1'b1);
        issue(OPV_XOR, HALF_RANGE, -HALF_RANGE, 1'b1);

        // Overflow at both ends of the range
        issue(OPV_ADD, HALF_RANGE, 1, 1'b1);
        issue(OPV_ADD, -HALF_RANGE, -1, 1'b1);
        issue(OPV_SUB, HALF_RANGE, -HALF_RANGE, 1'b1);
        issue(OPV_SUB, -HALF_RANGE, HALF_RANGE, 1'b1);
        issue(OPV_ADDI, HALF_RANGE, HALF_RANGE, 1'b1);

        // Equal operands and operands apart only in trit 0
        issue(OPV_LT, 3702, 3702, 1'b1);
        issue(OPV_EQ, 3702, 3702, 1'b1);
        issue(OPV_LT, 3702, 3703, 1'b1);
        issue(OPV_EQ, 3702, 3703, 1'b1);
        issue(OPV_LT, 3703, 3702, 1'b1);
        issue(OPV_LT, -3703, -3702, 1'b1);

        issue(OPV_COMP, 4321, -77, 1'b1);
        issue(0, -1200, 55, 1'b1);
        issue(-1, 999, 1, 1'b1);
        issue(-13, -HALF_RANGE, 2, 1'b1);
        issue(12, 17, -17, 1'b1);
        issue(13, HALF_RANGE, 0, 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue(random_opcode(), random_operand(), random_operand(),
                  $urandom_range(7) != 0);
        end

        // Load one result, then change everything with the enable low
        issue(OPV_ADD, 1234, -567, 1'b1);
        issue(OPV_SUB, random_operand(), random_operand(), 1'b0);
        held = int_to_word(wrap_balanced(1234 - 567));
        repeat (4) issue(random_opcode(), random_operand(), random_operand(), 1'b0);
        @(posedge clock);
        @(negedge clock);
        check_word("alu_out while disabled", alu_out, held);

        @(posedge clock);
        @(negedge clock);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- ternary_alu.f
+incdir+testbench
common/ternary_pkg.sv
verilog/alu_op_decoder.sv
verilog/trit_logic_unit.sv
arith/ternary_ripple_adder.sv
arith/ternary_comparator.sv
verilog/alu_result_register.sv
verilog/ternary_alu.sv
testbench/tb_ternary_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ternary ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -f ternary_alu.f \
    --top-module tb_ternary_alu --Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$("./$build_dir/Vtb_ternary_alu")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
